// File: filelist.f
logic/board_pkg.sv
logic/ctrl_regs.sv
logic/spi_master.sv
logic/spi_fanout.sv
logic/adc_capture.sv
logic/dac_output.sv
logic/board_top.sv
verification/tb_clkgen.sv
verification/board_chk.sv
verification/board_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the board interface testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module board_tb -f filelist.f -o board_sim

./obj_dir/board_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
   echo "Simulation ended without a result line"
   exit 1
fi
echo "Simulation finished cleanly"

// File: verification/board_tb.sv
`timescale 1ns/1ps

module board_tb;
   import board_pkg::*;

   localparam int SPI_TIMEOUT = 24 * 4 * SPI_DIV + 32;
   localparam int WD_HALF     = 2 ** WD_BIT;

   logic                  dsp_clk;
   logic                  arst_n;
   logic                  wr_stb;
   logic [1:0]            wr_addr;
   logic [31:0]           wr_data;
   logic [5:0]            leds;
   logic                  watchdog;
   logic [ADC_W-1:0]      adc_a, adc_b;
   logic [1:0]            adc_ovf;
   logic [1:0]            adc_pdn, adc_oen, ovf_sticky;
   logic [DAC_W-1:0]      dac_a, dac_b;
   logic [SPI_PORTS-1:0]  sen_n, sclk, mosi, miso;
   logic                  spi_done;
   logic [SPI_DATA_W-1:0] spi_rd_data;

   int               seed;
   ctrl_word_t       cur_ctrl;   // Last control word written
   logic [ADC_W-1:0] hist_a[$];
   logic [ADC_W-1:0] hist_b[$];

   tb_clkgen clkgen0 (.dsp_clk(dsp_clk), .arst_n_o(arst_n));

   board_top dut0
   (
      .dsp_clk       (dsp_clk),
      .arst_n_i      (arst_n),
      .wr_stb_i      (wr_stb),
      .wr_addr_i     (wr_addr),
      .wr_data_i     (wr_data),
      .leds_o        (leds),
      .watchdog_o    (watchdog),
      .adc_a_i       (adc_a),
      .adc_b_i       (adc_b),
      .adc_ovf_i     (adc_ovf),
      .adc_pdn_o     (adc_pdn),
      .adc_oen_o     (adc_oen),
      .ovf_sticky_o  (ovf_sticky),
      .dac_a_o       (dac_a),
      .dac_b_o       (dac_b),
      .sen_n_o       (sen_n),
      .sclk_o        (sclk),
      .mosi_o        (mosi),
      .miso_i        (miso),
      .spi_done_o    (spi_done),
      .spi_rd_data_o (spi_rd_data)
   );

   function automatic logic [31:0] rand32();
      rand32 = $random(seed);
   endfunction

   task automatic tick();
      @(posedge dsp_clk);
      #1;   // Drive and sample point
   endtask

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic value_error(input string msg);
      fail_now($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
   endtask

   task automatic check_leds(input logic [5:0] got, input logic [5:0] exp, input string what);
      if (got !== exp)
         value_error($sformatf("%s leds %b, expected %b", what, got, exp));
   endtask

   task automatic check_adc_pins(input logic [1:0] got, input logic [1:0] exp,
                                 input string what);
      if (got !== exp)
         value_error($sformatf("%s pins %b, expected %b", what, got, exp));
   endtask

   task automatic check_dac(input logic [DAC_W-1:0] got, input logic [DAC_W-1:0] exp,
                            input string what);
      if (got !== exp)
         value_error($sformatf("%s got %h, expected %h", what, got, exp));
   endtask

   task automatic check_spi(input logic [SPI_DATA_W-1:0] got,
                            input logic [SPI_DATA_W-1:0] exp, input string what);
      if (got !== exp)
         value_error($sformatf("%s got %h, expected %h", what, got, exp));
   endtask

   task automatic check_ovf(input logic [1:0] got, input logic [1:0] exp, input string what);
      if (got !== exp)
         value_error($sformatf("%s sticky %b, expected %b", what, got, exp));
   endtask

   task automatic check_period(input int got, input int exp, input string what);
      if (got != exp)
         value_error($sformatf("%s %0d cycles, expected %0d", what, got, exp));
   endtask

   task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
      wr_stb  = 1'b1;
      wr_addr = addr;
      wr_data = data;
      tick();
      wr_stb  = 1'b0;
   endtask

   task automatic write_ctrl(input ctrl_word_t cw);
      write_reg(REG_ADDR_CTRL, cw);
      cur_ctrl         = cw;
      cur_ctrl.ovf_clr = 1'b0;   // Strobe only and never stored
   endtask

   // Offset binary is two's complement with the sign bit flipped
   function automatic logic [DAC_W-1:0] dac_format(input logic [DAC_W-1:0] w, input logic ob);
      dac_format = ob ? {~w[DAC_W-1], w[DAC_W-2:0]} : w;
   endfunction

   function automatic logic [DAC_W-1:0] adc_to_dac(input logic [ADC_W-1:0] s);
      adc_to_dac = DAC_W'(s) << (DAC_W - ADC_W);
   endfunction

   function automatic ctrl_word_t random_ctrl();
      logic [31:0] r;
      ctrl_word_t  cw;
      r                 = rand32();
      cw                = '0;
      cw.leds           = r[5:0];
      cw.adc_on         = r[7:6];
      cw.adc_oe         = r[9:8];
      cw.dac_src        = dac_src_t'(r[11:10]);
      cw.dac_offset_bin = r[12];
      cw.wd_en          = r[13];
      random_ctrl       = cw;
   endfunction

   task automatic check_reset_state();
      check_leds(leds, LED_POLARITY, "Reset");   // All off
      check_adc_pins(adc_pdn, 2'b11, "Reset power-down");
      check_adc_pins(adc_oen, 2'b11, "Reset output enable");
      check_dac(dac_a, '0, "Reset DAC A");
      check_dac(dac_b, '0, "Reset DAC B");
      if (sen_n !== '1 || sclk !== '0 || mosi !== '0 || spi_done !== 1'b0 || watchdog !== 1'b0)
         value_error("SPI or watchdog pins not idle after reset");
   endtask

   task automatic ctrl_write_sweep(input int n);
      ctrl_word_t cw;
      for (int i = 0; i < n; i++)
      begin
         cw = random_ctrl();
         write_ctrl(cw);   // Pins checked one cycle after the strobe
         check_leds(leds, cw.leds ^ LED_POLARITY, "Control write");
         check_adc_pins(adc_pdn, ~cw.adc_on, "ADC power-down");
         check_adc_pins(adc_oen, ~cw.adc_oe, "ADC output enable");
         tick();
      end
   endtask

   task automatic dac_loopback_run(input dac_src_t src, input logic ob, input int n);
      ctrl_word_t       cw;
      logic [31:0]      r;
      logic [ADC_W-1:0] a_old, b_old;
      logic [DAC_W-1:0] exp_a, exp_b;
      cw                = cur_ctrl;
      cw.dac_src        = src;
      cw.dac_offset_bin = ob;
      write_ctrl(cw);
      hist_a.delete();
      hist_b.delete();
      for (int i = 0; i < n; i++)
      begin
         // Pins show the sample driven three points earlier
         if (hist_a.size() >= 3)
         begin
            a_old = hist_a[hist_a.size() - 3];
            b_old = hist_b[hist_b.size() - 3];
            exp_a = dac_format(adc_to_dac(src == DAC_SRC_SWAP ? b_old : a_old), ob);
            exp_b = dac_format(adc_to_dac(src == DAC_SRC_SWAP ? a_old : b_old), ob);
            check_dac(dac_a, exp_a, "DAC A loopback");
            check_dac(dac_b, exp_b, "DAC B loopback");
         end
         r     = rand32();
         adc_a = r[ADC_W-1:0];
         adc_b = r[ADC_W+15:16];
         hist_a.push_back(adc_a);
         hist_b.push_back(adc_b);
         tick();
      end
   endtask

   task automatic dac_const_run(input logic ob, input int n);
      ctrl_word_t  cw;
      logic [31:0] r;
      cw                = cur_ctrl;
      cw.dac_src        = DAC_SRC_CONST;
      cw.dac_offset_bin = ob;
      write_ctrl(cw);
      for (int i = 0; i < n; i++)
      begin
         r = rand32();
         write_reg(REG_ADDR_DAC, r);
         tick();
         check_dac(dac_a, dac_format(r[31:16], ob), "DAC A constant");
         check_dac(dac_b, dac_format(r[15:0], ob), "DAC B constant");
      end
   endtask

   task automatic spi_transfer();
      spi_cmd_t              cmd, cmd2;
      logic [31:0]           r;
      logic [SPI_DATA_W-1:0] pat, mask, rec;
      logic                  prev_sclk, sclk_now;
      int                    nbits, k, rises, waited, p;
      r            = rand32();
      cmd          = '0;
      cmd.port     = r[SPI_PORT_W-1:0];
      r            = rand32();
      nbits        = r % 24 + 1;
      cmd.nbits_m1 = SPI_CNT_W'(nbits - 1);
      r            = rand32();
      cmd.data     = r[SPI_DATA_W-1:0];
      r            = rand32();
      pat          = r[SPI_DATA_W-1:0];   // Slave reply
      mask         = (SPI_DATA_W'(1) << nbits) - SPI_DATA_W'(1);
      p            = int'(cmd.port);
      cmd2         = cmd;
      cmd2.port    = cmd.port + SPI_PORT_W'(1);
      cmd2.data    = ~cmd.data;
      write_reg(REG_ADDR_SPI, cmd);
      k         = nbits - 1;
      rises     = 0;
      rec       = '0;
      prev_sclk = 1'b0;
      waited    = 0;
      r         = rand32();
      miso      = r[SPI_PORTS-1:0];
      miso[p]   = pat[k];   // First reply bit ready before the first rise
      while (spi_done !== 1'b1)
      begin
         if (waited >= SPI_TIMEOUT)
            fail_now("Timeout waiting for spi_done_o");
         else
         begin
            if (waited == 2)
            begin
               // Lands while the master is busy
               wr_stb  = 1'b1;
               wr_addr = REG_ADDR_SPI;
               wr_data = cmd2;
            end
            tick();
            waited++;
            wr_stb   = 1'b0;
            sclk_now = sclk[p];
            // The slave only listens while its enable is low
            if (sclk_now && !prev_sclk && sen_n[p] === 1'b0)
            begin
               rec = {rec[SPI_DATA_W-2:0], mosi[p]};
               rises++;
            end
            if (!sclk_now && prev_sclk && k > 0)
               k--;   // Mode 0 moves to the next bit after the fall
            prev_sclk = sclk_now;
            r         = rand32();
            miso      = r[SPI_PORTS-1:0];   // Noise on the other ports
            miso[p]   = pat[k];
         end
      end
      if (rises != nbits)
         value_error($sformatf("Slave saw %0d sclk rises, expected %0d", rises, nbits));
      check_spi(rec, cmd.data & mask, "MOSI bits at the slave");
      check_spi(spi_rd_data, pat & mask, "SPI read data");
      for (int i = 0; i < 8 * SPI_DIV; i++)
      begin
         tick();
         if (sen_n !== '1)
            value_error("SPI write during a transfer was not ignored");
      end
      miso = '0;
   endtask

   task automatic ovf_pulse_clear();
      ctrl_word_t  cw;
      logic [31:0] r;
      logic [1:0]  which;
      int          waited;
      r       = rand32();
      which   = r[0] ? 2'b10 : 2'b01;
      adc_ovf = which;
      tick();
      adc_ovf = 2'b00;
      waited  = 0;
      while (ovf_sticky === 2'b00)
      begin
         if (waited >= 10)
            fail_now("Timeout waiting for a sticky overflow flag");
         else
         begin
            tick();
            waited++;
         end
      end
      check_ovf(ovf_sticky, which, "After pulse");
      repeat (r[7:4]) tick();
      check_ovf(ovf_sticky, which, "Held");
      cw         = cur_ctrl;
      cw.ovf_clr = 1'b1;
      write_ctrl(cw);
      tick();   // Strobe register then flag
      check_ovf(ovf_sticky, 2'b00, "After clear");
   endtask

   // Counts points until watchdog_o reaches the level
   task automatic measure_watchdog(input logic level, input int limit, output int cnt);
      cnt = 0;
      while (watchdog !== level)
      begin
         if (cnt >= limit)
            fail_now($sformatf("Timeout waiting for watchdog_o to reach %b", level));
         else
         begin
            tick();
            cnt++;
         end
      end
   endtask

   task automatic watchdog_period();
      ctrl_word_t cw;
      int         cnt;
      cw       = cur_ctrl;
      cw.wd_en = 1'b0;
      write_ctrl(cw);
      tick();
      for (int i = 0; i < 2 * WD_HALF + 4; i++)
      begin
         if (watchdog !== 1'b0)
            value_error("watchdog_o moved while disabled");
         tick();
      end
      cw.wd_en = 1'b1;
      write_ctrl(cw);
      measure_watchdog(1'b1, 2 * WD_HALF + 8, cnt);
      measure_watchdog(1'b0, WD_HALF + 8, cnt);
      check_period(cnt, WD_HALF, "Watchdog high time");
      measure_watchdog(1'b1, WD_HALF + 8, cnt);
      check_period(cnt, WD_HALF, "Watchdog low time");
      cw.wd_en = 1'b0;
      write_ctrl(cw);
   endtask

   // Polls the failure count of the bound checker
   always @(posedge dsp_clk)
   begin
      if (dut0.chk0.fail_cnt != 0)
         fail_now("A bound assertion in board_chk failed");
   end

   initial
   begin
      int waited;
      seed     = 32'h3830_e3d1;
      wr_stb   = 1'b0;
      wr_addr  = '0;
      wr_data  = '0;
      adc_a    = '0;
      adc_b    = '0;
      adc_ovf  = '0;
      miso     = '0;
      cur_ctrl = '0;
      waited   = 0;
      while (arst_n !== 1'b1)
      begin
         if (waited >= 20)
            fail_now("Timeout waiting for reset release");
         else
         begin
            tick();
            waited++;
         end
      end
      tick();
      check_reset_state();
      ctrl_write_sweep(20);
      dac_loopback_run(DAC_SRC_LOOP, 1'b0, 30);
      dac_loopback_run(DAC_SRC_LOOP, 1'b1, 30);
      dac_loopback_run(DAC_SRC_SWAP, 1'b0, 30);
      dac_loopback_run(DAC_SRC_SWAP, 1'b1, 30);
      dac_const_run(1'b0, 8);
      dac_const_run(1'b1, 8);
      repeat (12) spi_transfer();
      repeat (6) ovf_pulse_clear();
      watchdog_period();
      if (dut0.chk0.fail_cnt == 0)
      begin
         $display("RESULT: PASS");
         $finish;
      end
      else
      begin
         $display("Bound assertion failures: %0d", dut0.chk0.fail_cnt);
         $display("RESULT: FAIL");
         $fatal(1, "Assertion failures in board_chk");
      end
   end

endmodule

// File: verification/board_chk.sv
`timescale 1ns/1ps

module board_chk
(
   input  logic                                dsp_clk,
   input  logic                                arst_n_i,
   input  logic [board_pkg::SPI_PORTS-1:0]     sen_n_i,
   input  logic [board_pkg::SPI_PORTS-1:0]     sclk_i,
   input  logic                                spi_done_i
);

   int unsigned fail_cnt = 0;   // Read by the testbench

   // At most one peripheral enabled
   one_sen_a: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      $onehot0(~sen_n_i))
   else
   begin
      fail_cnt++;
      $error("More than one sen_n low %b", sen_n_i);
   end

   quiet_sclk_a: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      (sclk_i & sen_n_i) == '0)
   else
   begin
      fail_cnt++;
      $error("sclk active on a deselected port %b", sclk_i & sen_n_i);
   end

   done_pulse_a: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      spi_done_i |=> !spi_done_i)
   else
   begin
      fail_cnt++;
      $error("spi_done_o longer than one cycle");
   end

endmodule

bind board_top board_chk chk0
(
   .dsp_clk    (dsp_clk),
   .arst_n_i   (arst_n_i),
   .sen_n_i    (sen_n_o),
   .sclk_i     (sclk_o),
   .spi_done_i (spi_done_o)
);

// File: verification/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen
(
   output logic dsp_clk,
   output logic arst_n_o
);

   // 10 ns period
   initial
   begin
      dsp_clk = 1'b0;
      forever #5 dsp_clk = ~dsp_clk;
   end

   // Low through the first five rising edges and released on a falling edge
   initial
   begin
      arst_n_o = 1'b0;
      repeat (5) @(posedge dsp_clk);
      @(negedge dsp_clk);
      arst_n_o = 1'b1;
   end

endmodule

// File: logic/board_top.sv
`timescale 1ns/1ps

module board_top
(
   input  logic                                dsp_clk,
   input  logic                                arst_n_i,
   // Register port
   input  logic                                wr_stb_i,
   input  logic [1:0]                          wr_addr_i,
   input  logic [31:0]                         wr_data_i,
   // Misc board pins
   output logic [5:0]                          leds_o,
   output logic                                watchdog_o,
   // ADC
   input  logic [board_pkg::ADC_W-1:0]         adc_a_i,
   input  logic [board_pkg::ADC_W-1:0]         adc_b_i,
   input  logic [1:0]                          adc_ovf_i,
   output logic [1:0]                          adc_pdn_o,
   output logic [1:0]                          adc_oen_o,
   output logic [1:0]                          ovf_sticky_o,
   // DAC
   output logic [board_pkg::DAC_W-1:0]         dac_a_o,
   output logic [board_pkg::DAC_W-1:0]         dac_b_o,
   // SPI peripheral ports
   output logic [board_pkg::SPI_PORTS-1:0]     sen_n_o,
   output logic [board_pkg::SPI_PORTS-1:0]     sclk_o,
   output logic [board_pkg::SPI_PORTS-1:0]     mosi_o,
   input  logic [board_pkg::SPI_PORTS-1:0]     miso_i,
   output logic                                spi_done_o,
   output logic [board_pkg::SPI_DATA_W-1:0]    spi_rd_data_o
);
   import board_pkg::*;

   logic                  spi_start, spi_busy;
   logic [SPI_PORT_W-1:0] spi_port, spi_port_act;
   logic [SPI_CNT_W-1:0]  spi_nbits_m1;
   logic [SPI_DATA_W-1:0] spi_data;
   logic                  spi_sclk, spi_mosi, spi_miso, spi_cs;

   dac_src_t              dac_src;
   logic                  dac_offset_bin;
   logic [DAC_W-1:0]      dac_const_a, dac_const_b;
   logic                  ovf_clr;
   logic [ADC_W-1:0]      adc_a_cap, adc_b_cap;

   ctrl_regs ctrl_regs0
   (
      .dsp_clk          (dsp_clk),
      .arst_n_i         (arst_n_i),
      .wr_stb_i         (wr_stb_i),
      .wr_addr_i        (wr_addr_i),
      .wr_data_i        (wr_data_i),
      .spi_busy_i       (spi_busy),
      .spi_start_o      (spi_start),
      .spi_port_o       (spi_port),
      .spi_nbits_m1_o   (spi_nbits_m1),
      .spi_data_o       (spi_data),
      .dac_src_o        (dac_src),
      .dac_offset_bin_o (dac_offset_bin),
      .dac_const_a_o    (dac_const_a),
      .dac_const_b_o    (dac_const_b),
      .ovf_clr_o        (ovf_clr),
      .leds_o           (leds_o),
      .adc_pdn_o        (adc_pdn_o),
      .adc_oen_o        (adc_oen_o),
      .wdi_o            (watchdog_o)
   );

   spi_master spi_master0
   (
      .dsp_clk     (dsp_clk),
      .arst_n_i    (arst_n_i),
      .start_i     (spi_start),
      .port_i      (spi_port),
      .nbits_m1_i  (spi_nbits_m1),
      .data_i      (spi_data),
      .miso_i      (spi_miso),
      .busy_o      (spi_busy),
      .sclk_o      (spi_sclk),
      .mosi_o      (spi_mosi),
      .port_o      (spi_port_act),
      .cs_active_o (spi_cs),
      .done_o      (spi_done_o),
      .rd_data_o   (spi_rd_data_o)
   );

   spi_fanout spi_fanout0
   (
      .sclk_i      (spi_sclk),
      .mosi_i      (spi_mosi),
      .port_i      (spi_port_act),
      .cs_active_i (spi_cs),
      .sen_n_o     (sen_n_o),
      .sclk_o      (sclk_o),
      .mosi_o      (mosi_o),
      .miso_i      (miso_i),
      .miso_o      (spi_miso)
   );

   adc_capture adc_capture0
   (
      .dsp_clk      (dsp_clk),
      .arst_n_i     (arst_n_i),
      .adc_a_i      (adc_a_i),
      .adc_b_i      (adc_b_i),
      .adc_ovf_i    (adc_ovf_i),
      .ovf_clr_i    (ovf_clr),
      .adc_a_o      (adc_a_cap),
      .adc_b_o      (adc_b_cap),
      .ovf_sticky_o (ovf_sticky_o)
   );

   dac_output dac_output0
   (
      .dsp_clk      (dsp_clk),
      .arst_n_i     (arst_n_i),
      .src_i        (dac_src),
      .offset_bin_i (dac_offset_bin),
      .const_a_i    (dac_const_a),
      .const_b_i    (dac_const_b),
      .adc_a_i      (adc_a_cap),
      .adc_b_i      (adc_b_cap),
      .dac_a_o      (dac_a_o),
      .dac_b_o      (dac_b_o)
   );

endmodule

// File: logic/dac_output.sv
`timescale 1ns/1ps

module dac_output
(
   input  logic                          dsp_clk,
   input  logic                          arst_n_i,
   input  board_pkg::dac_src_t           src_i,
   input  logic                          offset_bin_i,
   input  logic [board_pkg::DAC_W-1:0]   const_a_i,
   input  logic [board_pkg::DAC_W-1:0]   const_b_i,
   input  logic [board_pkg::ADC_W-1:0]   adc_a_i,
   input  logic [board_pkg::ADC_W-1:0]   adc_b_i,
   output logic [board_pkg::DAC_W-1:0]   dac_a_o,
   output logic [board_pkg::DAC_W-1:0]   dac_b_o
);
   import board_pkg::*;

   logic [DAC_W-1:0] loop_a, loop_b;
   logic [DAC_W-1:0] sel_a, sel_b;
   logic [DAC_W-1:0] msb_flip;

   // ADC sample into the top of the DAC word
   assign loop_a = {adc_a_i, {(DAC_W-ADC_W){1'b0}}};
   assign loop_b = {adc_b_i, {(DAC_W-ADC_W){1'b0}}};

   always_comb
   begin
      case (src_i)
         DAC_SRC_CONST:
         begin
            sel_a = const_a_i;
            sel_b = const_b_i;
         end
         DAC_SRC_LOOP:
         begin
            sel_a = loop_a;
            sel_b = loop_b;
         end
         DAC_SRC_SWAP:
         begin
            sel_a = loop_b;
            sel_b = loop_a;
         end
         default:
         begin
            sel_a = '0;
            sel_b = '0;
         end
      endcase
   end

   assign msb_flip = {offset_bin_i, {(DAC_W-1){1'b0}}};   // Two's complement to offset binary

   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         dac_a_o <= '0;
         dac_b_o <= '0;
      end
      else
      begin
         dac_a_o <= sel_a ^ msb_flip;
         dac_b_o <= sel_b ^ msb_flip;
      end
   end

endmodule

// File: logic/adc_capture.sv
`timescale 1ns/1ps

module adc_capture
(
   input  logic                          dsp_clk,
   input  logic                          arst_n_i,
   input  logic [board_pkg::ADC_W-1:0]   adc_a_i,
   input  logic [board_pkg::ADC_W-1:0]   adc_b_i,
   input  logic [1:0]                    adc_ovf_i,
   input  logic                          ovf_clr_i,
   output logic [board_pkg::ADC_W-1:0]   adc_a_o,
   output logic [board_pkg::ADC_W-1:0]   adc_b_o,
   output logic [1:0]                    ovf_sticky_o
);
   import board_pkg::*;

   logic [ADC_W-1:0] a_s1, b_s1;
   logic [1:0]       ovf_s1, ovf_s2;

   // Two stage sample pipeline from the pins
   always_ff @(posedge dsp_clk)
   begin
      a_s1    <= adc_a_i;
      b_s1    <= adc_b_i;
      adc_a_o <= a_s1;
      adc_b_o <= b_s1;
   end

   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ovf_s1       <= '0;
         ovf_s2       <= '0;
         ovf_sticky_o <= '0;
      end
      else
      begin
         ovf_s1       <= adc_ovf_i;
         ovf_s2       <= ovf_s1;
         ovf_sticky_o <= ovf_s2 | (ovf_sticky_o & ~{2{ovf_clr_i}});   // Set beats clear
      end
   end

endmodule

// File: logic/spi_fanout.sv
`timescale 1ns/1ps

module spi_fanout
(
   input  logic                                sclk_i,
   input  logic                                mosi_i,
   input  logic [board_pkg::SPI_PORT_W-1:0]    port_i,
   input  logic                                cs_active_i,
   output logic [board_pkg::SPI_PORTS-1:0]     sen_n_o,
   output logic [board_pkg::SPI_PORTS-1:0]     sclk_o,
   output logic [board_pkg::SPI_PORTS-1:0]     mosi_o,
   input  logic [board_pkg::SPI_PORTS-1:0]     miso_i,
   output logic                                miso_o
);
   import board_pkg::*;

   logic [SPI_PORTS-1:0] sel;

   always_comb
   begin
      sel = '0;
      if (cs_active_i)
         sel[port_i] = 1'b1;
   end

   assign sen_n_o = ~sel;
   // Deselected ports stay low
   assign sclk_o  = sel & {SPI_PORTS{sclk_i}};
   assign mosi_o  = sel & {SPI_PORTS{mosi_i}};

   // Read back from whichever port is enabled
   assign miso_o  = |(sel & miso_i);

endmodule

// File: logic/spi_master.sv
`timescale 1ns/1ps

module spi_master
(
   input  logic                                dsp_clk,
   input  logic                                arst_n_i,
   input  logic                                start_i,
   input  logic [board_pkg::SPI_PORT_W-1:0]    port_i,
   input  logic [board_pkg::SPI_CNT_W-1:0]     nbits_m1_i,
   input  logic [board_pkg::SPI_DATA_W-1:0]    data_i,
   input  logic                                miso_i,
   output logic                                busy_o,
   output logic                                sclk_o,
   output logic                                mosi_o,
   output logic [board_pkg::SPI_PORT_W-1:0]    port_o,
   output logic                                cs_active_o,
   output logic                                done_o,
   output logic [board_pkg::SPI_DATA_W-1:0]    rd_data_o
);
   import board_pkg::*;

   localparam int TOP   = SPI_DATA_W - 1;
   localparam int DIV_W = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_DIV - 1);

   logic                  active_q;
   logic                  sclk_q;
   logic                  done_q;
   logic [DIV_W-1:0]      div_q;
   logic [SPI_CNT_W-1:0]  bit_q;      // Bits left after the current one
   logic [SPI_DATA_W-1:0] tx_q;
   logic [SPI_DATA_W-1:0] rx_q;
   logic [SPI_PORT_W-1:0] port_q;

   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         active_q <= 1'b0;
         sclk_q   <= 1'b0;
         done_q   <= 1'b0;
         div_q    <= '0;
         bit_q    <= '0;
         tx_q     <= '0;
         rx_q     <= '0;
         port_q   <= '0;
      end
      else
      begin
         done_q <= 1'b0;
         if (!active_q)
         begin
            if (start_i)
            begin
               active_q <= 1'b1;
               port_q   <= port_i;
               bit_q    <= nbits_m1_i;
               tx_q     <= data_i << (TOP - nbits_m1_i);   // First bit to the MSB
               rx_q     <= '0;
               div_q    <= '0;
               sclk_q   <= 1'b0;
            end
         end
         else if (div_q == DIV_LAST)
         begin
            div_q <= '0;
            if (!sclk_q)
            begin
               // Rising edge samples miso
               sclk_q <= 1'b1;
               rx_q   <= {rx_q[TOP-1:0], miso_i};
            end
            else
            begin
               sclk_q <= 1'b0;
               if (bit_q == '0)
               begin
                  active_q <= 1'b0;
                  done_q   <= 1'b1;
               end
               else
               begin
                  bit_q <= bit_q - 1'b1;
                  tx_q  <= {tx_q[TOP-1:0], 1'b0};   // Next bit on the fall
               end
            end
         end
         else
            div_q <= div_q + 1'b1;
      end
   end

   assign busy_o      = active_q;
   assign cs_active_o = active_q;
   assign sclk_o      = sclk_q;
   assign mosi_o      = tx_q[TOP];
   assign port_o      = port_q;
   assign done_o      = done_q;
   assign rd_data_o   = rx_q;   // Right aligned and held until the next start

endmodule

// File: logic/ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs
(
   input  logic                                dsp_clk,
   input  logic                                arst_n_i,
   input  logic                                wr_stb_i,
   input  logic [1:0]                          wr_addr_i,
   input  board_pkg::reg_word_u                wr_data_i,
   input  logic                                spi_busy_i,
   output logic                                spi_start_o,
   output logic [board_pkg::SPI_PORT_W-1:0]    spi_port_o,
   output logic [board_pkg::SPI_CNT_W-1:0]     spi_nbits_m1_o,
   output logic [board_pkg::SPI_DATA_W-1:0]    spi_data_o,
   output board_pkg::dac_src_t                 dac_src_o,
   output logic                                dac_offset_bin_o,
   output logic [board_pkg::DAC_W-1:0]         dac_const_a_o,
   output logic [board_pkg::DAC_W-1:0]         dac_const_b_o,
   output logic                                ovf_clr_o,
   output logic [5:0]                          leds_o,
   output logic [1:0]                          adc_pdn_o,
   output logic [1:0]                          adc_oen_o,
   output logic                                wdi_o
);
   import board_pkg::*;

   logic [5:0]    leds_q;
   logic [1:0]    adc_on_q;
   logic [1:0]    adc_oe_q;
   logic          wd_en_q;
   logic [WD_BIT:0] wd_cnt_q;

   logic wr_ctrl;
   logic wr_dac;

   assign wr_ctrl = wr_stb_i && (wr_addr_i == REG_ADDR_CTRL);
   assign wr_dac  = wr_stb_i && (wr_addr_i == REG_ADDR_DAC);

   // SPI command passes straight through and starts only when the engine is idle
   assign spi_start_o    = wr_stb_i && (wr_addr_i == REG_ADDR_SPI) && !spi_busy_i;
   assign spi_port_o     = wr_data_i.spi.port;
   assign spi_nbits_m1_o = wr_data_i.spi.nbits_m1;
   assign spi_data_o     = wr_data_i.spi.data;

   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         leds_q           <= '0;
         adc_on_q         <= '0;
         adc_oe_q         <= '0;
         wd_en_q          <= 1'b0;
         dac_src_o        <= DAC_SRC_ZERO;
         dac_offset_bin_o <= 1'b0;
         ovf_clr_o        <= 1'b0;
         dac_const_a_o    <= '0;
         dac_const_b_o    <= '0;
      end
      else
      begin
         ovf_clr_o <= wr_ctrl && wr_data_i.ctrl.ovf_clr;   // One cycle pulse
         if (wr_ctrl)
         begin
            leds_q           <= wr_data_i.ctrl.leds;
            adc_on_q         <= wr_data_i.ctrl.adc_on;
            adc_oe_q         <= wr_data_i.ctrl.adc_oe;
            wd_en_q          <= wr_data_i.ctrl.wd_en;
            dac_src_o        <= wr_data_i.ctrl.dac_src;
            dac_offset_bin_o <= wr_data_i.ctrl.dac_offset_bin;
         end
         if (wr_dac)
         begin
            dac_const_a_o <= wr_data_i[31:16];
            dac_const_b_o <= wr_data_i[15:0];
         end
      end
   end

   // Watchdog kicker held at zero while disabled
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         wd_cnt_q <= '0;
      else if (wd_en_q)
         wd_cnt_q <= wd_cnt_q + 1'b1;
      else
         wd_cnt_q <= '0;
   end

   assign wdi_o     = wd_cnt_q[WD_BIT];
   assign leds_o    = leds_q ^ LED_POLARITY;
   assign adc_pdn_o = ~adc_on_q;   // Pins are active low
   assign adc_oen_o = ~adc_oe_q;

endmodule

// File: logic/board_pkg.sv
package board_pkg;

   // Register port addresses
   localparam logic [1:0] REG_ADDR_CTRL = 2'd0;
   localparam logic [1:0] REG_ADDR_SPI  = 2'd1;
   localparam logic [1:0] REG_ADDR_DAC  = 2'd2;

   localparam int ADC_W = 14;
   localparam int DAC_W = 16;

   // SPI engine sizing
   localparam int SPI_PORTS  = 8;
   localparam int SPI_PORT_W = $clog2(SPI_PORTS);
   localparam int SPI_CNT_W  = 5;
   localparam int SPI_DATA_W = 24;
   localparam int SPI_DIV    = 2;   // dsp_clk cycles per sclk half period

   localparam logic [5:0] LED_POLARITY = 6'b011111;   // All but the Ethernet LED active low
   localparam int WD_BIT = 9;

   typedef enum logic [1:0]
   {
      DAC_SRC_CONST = 2'd0,
      DAC_SRC_LOOP  = 2'd1,
      DAC_SRC_SWAP  = 2'd2,
      DAC_SRC_ZERO  = 2'd3
   } dac_src_t;

   typedef struct packed
   {
      logic [5:0]  leds;
      logic [1:0]  adc_on;
      logic [1:0]  adc_oe;
      dac_src_t    dac_src;
      logic        dac_offset_bin;
      logic        ovf_clr;   // Self clearing
      logic        wd_en;
      logic [16:0] padding;
   } ctrl_word_t;

   typedef struct packed
   {
      logic [SPI_PORT_W-1:0] port;
      logic [SPI_CNT_W-1:0]  nbits_m1;   // Transfer length minus one
      logic [SPI_DATA_W-1:0] data;       // Right aligned
   } spi_cmd_t;

   // Two views of the same write data word
   typedef union packed
   {
      ctrl_word_t ctrl;
      spi_cmd_t   spi;
   } reg_word_u;

endpackage
